// File: fifo_settings.svh
// FIFO depth and data width defines.
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// Number of words held by the FIFO.
// Must be a power of two and at least 2.
`define FIFO_DEPTH 16

// Bit width of one stored word.
`define FIFO_DATA_WIDTH 32

`endif

// File: fifo_pkg.sv
// Package with the FIFO word, address, pointer and occupancy types.
`default_nettype none

`include "fifo_settings.svh"

package fifo_pkg;

  localparam int depth      = `FIFO_DEPTH;
  localparam int addr_width = $clog2(depth);

  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [addr_width-1:0]       addr_t;

  // The top bit of a pointer flips on every wrap of the address range.
  typedef logic [addr_width:0]         ptr_t;

  // Occupancy runs from 0 up to depth, so it needs one bit over the address.
  typedef logic [addr_width:0]         count_t;

endpackage

`default_nettype wire

// File: ram_wr_if.sv
// RAM write-port interface with writer and RAM modports.
`timescale 1ns/10ps
`default_nettype none

interface ram_wr_if
  import fifo_pkg::*;
();

  // Memory enable and write enable; a word is stored only when both are high.
  logic  mea;
  logic  wea;
  addr_t adra;
  data_t da;

  modport writer (
    output mea,
    output wea,
    output adra,
    output da
  );

  modport ram (
    input mea,
    input wea,
    input adra,
    input da
  );

endinterface

`default_nettype wire

// File: dp_ram.sv
// Simple dual-port RAM with one write port and a registered read port.
`timescale 1ns/10ps
`default_nettype none

module dp_ram
  import fifo_pkg::*;
#(
  parameter int WORD_SIZE  = 16,
  parameter int DATA_WIDTH = 32
)(
  input  var logic  i_clk,
  input  var logic  i_rst_n,
  ram_wr_if.ram     i_wr,
  input  var logic  i_meb,
  input  var addr_t i_adrb,
  output var data_t o_qb
);

  // Storage array with one entry per FIFO slot.
  logic [DATA_WIDTH-1:0] mem [WORD_SIZE];

  // Read register in front of the output.
  data_t q;

  // Write port. A word lands on the edge where both strobes are high.
  always_ff @(posedge i_clk) begin
    if (i_wr.mea && i_wr.wea) begin
      mem[i_wr.adra] <= DATA_WIDTH'(i_wr.da);
    end
  end

  // Read port.
  // The register only loads when the read strobe is high, so the
  // last word read stays on the output between reads.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      q <= '0;
    end else if (i_meb) begin
      q <= data_t'(mem[i_adrb]);
    end
  end

  always_comb begin
    o_qb = q;
  end

endmodule

`default_nettype wire

// File: fifo_write_ctrl.sv
// FIFO input side: write pointer, full flag and RAM write drive.
`timescale 1ns/10ps
`default_nettype none

module fifo_write_ctrl
  import fifo_pkg::*;
(
  input  var logic  i_clk,
  input  var logic  i_rst_n,
  input  var logic  i_clr,
  input  var logic  i_push,
  input  var data_t i_push_data,
  input  var ptr_t  i_rd_ptr,
  ram_wr_if.writer  o_wr,
  output var ptr_t  o_wr_ptr,
  output var logic  o_full
);

  ptr_t  wr_ptr;
  addr_t wr_addr;
  addr_t rd_addr;
  logic  push_ok;

  assign wr_addr = wr_ptr[addr_width-1:0];
  assign rd_addr = i_rd_ptr[addr_width-1:0];

  // Full when both pointers sit on the same slot but one has wrapped
  // once more than the other.
  always_comb begin
    o_full = (wr_addr == rd_addr) &&
             (wr_ptr[addr_width] != i_rd_ptr[addr_width]);
  end

  // The memory enable follows the push request and the write enable
  // carries the room check. A clear in the same cycle wins over a push.
  always_comb begin
    o_wr.mea  = i_push && !i_clr;
    o_wr.wea  = !o_full;
    o_wr.adra = wr_addr;
    o_wr.da   = i_push_data;
  end

  assign push_ok = o_wr.mea && o_wr.wea;

  // Write pointer.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
    end else if (i_clr) begin
      wr_ptr <= '0;
    end else if (push_ok) begin
      wr_ptr <= wr_ptr + ptr_t'(1);
    end
  end

  assign o_wr_ptr = wr_ptr;

endmodule

`default_nettype wire

// File: fifo_read_ctrl.sv
// FIFO output side: read pointer, empty and count, RAM read and pop valid.
`timescale 1ns/10ps
`default_nettype none

module fifo_read_ctrl
  import fifo_pkg::*;
(
  input  var logic   i_clk,
  input  var logic   i_rst_n,
  input  var logic   i_clr,
  input  var logic   i_pop,
  input  var ptr_t   i_wr_ptr,
  output var logic   o_ram_re,
  output var addr_t  o_ram_addr,
  input  var data_t  i_ram_q,
  output var ptr_t   o_rd_ptr,
  output var logic   o_empty,
  output var count_t o_count,
  output var logic   o_pop_valid,
  output var data_t  o_pop_data
);

  ptr_t rd_ptr;
  ptr_t ptr_diff;
  logic pop_ok;
  logic valid_q;

  // Empty when the pointers match, wrap bit included.
  always_comb begin
    o_empty = (rd_ptr == i_wr_ptr);
  end

  // The pointer difference modulo 2*depth gives the occupancy directly,
  // including the full case where it equals depth.
  always_comb begin
    ptr_diff = i_wr_ptr - rd_ptr;
    o_count  = count_t'(ptr_diff);
  end

  // A pop is taken only when there is data and no clear is pending.
  always_comb begin
    pop_ok = i_pop && !o_empty && !i_clr;
  end

  // The RAM is read at the current head slot in the cycle of the pop,
  // so the word sits in the RAM read register right after the edge.
  always_comb begin
    o_ram_re   = pop_ok;
    o_ram_addr = rd_ptr[addr_width-1:0];
  end

  // Read pointer.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_ptr <= '0;
    end else if (i_clr) begin
      rd_ptr <= '0;
    end else if (pop_ok) begin
      rd_ptr <= rd_ptr + ptr_t'(1);
    end
  end

  // Valid flag.
  // It is set by the same edge that loads the RAM read register, which
  // lines it up with the returned word. A new pop in the valid cycle
  // simply keeps it high for the next word.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (i_clr) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pop_ok;
    end
  end

  always_comb begin
    o_rd_ptr    = rd_ptr;
    o_pop_valid = valid_q;
  end

  // The RAM read register only changes on a read, so the popped word
  // holds here until the next accepted pop.
  always_comb begin
    o_pop_data = i_ram_q;
  end

endmodule

`default_nettype wire

// File: fifo_top.sv
// FIFO top level tying the write control, the RAM and the read control.
`timescale 1ns/10ps
`default_nettype none

`include "fifo_settings.svh"

module fifo_top
  import fifo_pkg::*;
(
  input  var logic   i_clk,
  input  var logic   i_rst_n,
  input  var logic   i_clr,

  // Push side.
  input  var logic   i_push,
  input  var data_t  i_push_data,

  // Pop side.
  input  var logic   i_pop,
  output var logic   o_pop_valid,
  output var data_t  o_pop_data,

  // Status.
  output var logic   o_full,
  output var logic   o_empty,
  output var count_t o_count
);

  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  logic  ram_re;
  addr_t ram_addr;
  data_t ram_q;

  ram_wr_if ram_wr ();

  fifo_write_ctrl u_wr_ctrl (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_clr       (i_clr),
    .i_push      (i_push),
    .i_push_data (i_push_data),
    .i_rd_ptr    (rd_ptr),
    .o_wr        (ram_wr.writer),
    .o_wr_ptr    (wr_ptr),
    .o_full      (o_full)
  );

  // Depth and width come straight from the FIFO defines.
  dp_ram #(
    .WORD_SIZE  (`FIFO_DEPTH),
    .DATA_WIDTH (`FIFO_DATA_WIDTH)
  ) u_ram (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wr    (ram_wr.ram),
    .i_meb   (ram_re),
    .i_adrb  (ram_addr),
    .o_qb    (ram_q)
  );

  fifo_read_ctrl u_rd_ctrl (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_clr       (i_clr),
    .i_pop       (i_pop),
    .i_wr_ptr    (wr_ptr),
    .o_ram_re    (ram_re),
    .o_ram_addr  (ram_addr),
    .i_ram_q     (ram_q),
    .o_rd_ptr    (rd_ptr),
    .o_empty     (o_empty),
    .o_count     (o_count),
    .o_pop_valid (o_pop_valid),
    .o_pop_data  (o_pop_data)
  );

endmodule

`default_nettype wire

// File: tb_fifo.sv
// Directed testbench for the FIFO top level with a queue reference model.
`timescale 1ns/10ps
`default_nettype none

`include "fifo_settings.svh"

module tb_fifo
  import fifo_pkg::*;
();

  localparam int DEPTH = `FIFO_DEPTH;

  logic   i_clk;
  logic   i_rst_n;
  logic   i_clr;
  logic   i_push;
  data_t  i_push_data;
  logic   i_pop;
  logic   o_pop_valid;
  data_t  o_pop_data;
  logic   o_full;
  logic   o_empty;
  count_t o_count;

  // Reference model state.
  data_t       model_q[$];
  logic        exp_valid;
  data_t       exp_data;
  logic [31:0] lcg_state;

  fifo_top dut_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_clr       (i_clr),
    .i_push      (i_push),
    .i_push_data (i_push_data),
    .i_pop       (i_pop),
    .o_pop_valid (o_pop_valid),
    .o_pop_data  (o_pop_data),
    .o_full      (o_full),
    .o_empty     (o_empty),
    .o_count     (o_count)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, expected);
      $display("=== FAIL ===");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  // Compares every output against the model after an edge.
  task automatic compare_outputs();
    check_value("o_pop_valid", 64'(o_pop_valid), 64'(exp_valid));
    check_value("o_pop_data", 64'(o_pop_data), 64'(exp_data));
    check_value("o_count", 64'(o_count), 64'(model_q.size()));
    check_value("o_empty", 64'(o_empty), 64'(model_q.size() == 0));
    check_value("o_full", 64'(o_full), 64'(model_q.size() == DEPTH));
  endtask

  // Drives one cycle from a falling edge, updates the model at the rising
  // edge and checks the outputs at the next falling edge.
  task automatic drive_cycle(input logic push, input data_t data,
                             input logic pop, input logic clr);
    int   size_before;
    logic push_ok;
    logic pop_ok;
    size_before = model_q.size();
    push_ok     = push && !clr && (size_before < DEPTH);
    pop_ok      = pop && !clr && (size_before > 0);
    i_push      = push;
    i_push_data = data;
    i_pop       = pop;
    i_clr       = clr;
    @(posedge i_clk);
    if (clr) begin
      model_q.delete();
      exp_valid = 1'b0;
    end else begin
      if (pop_ok) begin
        exp_data = model_q.pop_front();
      end
      exp_valid = pop_ok;
      if (push_ok) begin
        model_q.push_back(data);
      end
    end
    @(negedge i_clk);
    i_push = 1'b0;
    i_pop  = 1'b0;
    i_clr  = 1'b0;
    compare_outputs();
  endtask

  task automatic check_reset_state();
    compare_outputs();
    repeat (5) drive_cycle(1'b0, '0, 1'b0, 1'b0);
  endtask

  task automatic fill_and_drain();
    for (int i = 0; i < DEPTH; i++) begin
      drive_cycle(1'b1, data_t'(lcg_next()), 1'b0, 1'b0);
    end
    // Back to back pops; every cycle must carry the next word.
    for (int i = 0; i < DEPTH; i++) begin
      drive_cycle(1'b0, '0, 1'b1, 1'b0);
    end
    drive_cycle(1'b0, '0, 1'b0, 1'b0);
  endtask

  task automatic overflow_drop();
    for (int i = 0; i < DEPTH; i++) begin
      drive_cycle(1'b1, data_t'(lcg_next()), 1'b0, 1'b0);
    end
    check_value("o_full", 64'(o_full), 64'd1);
    check_value("o_count", 64'(o_count), 64'(DEPTH));
    repeat (3) drive_cycle(1'b1, data_t'(lcg_next()), 1'b0, 1'b0);
    while (model_q.size() > 0) begin
      drive_cycle(1'b0, '0, 1'b1, 1'b0);
    end
    drive_cycle(1'b0, '0, 1'b0, 1'b0);
  endtask

  task automatic underflow_ignore();
    repeat (5) drive_cycle(1'b0, '0, 1'b1, 1'b0);
    check_value("o_count", 64'(o_count), 64'd0);
  endtask

  task automatic mixed_traffic();
    logic [31:0] r;
    logic        push;
    logic        pop;
    while (model_q.size() < DEPTH) begin
      drive_cycle(1'b1, data_t'(lcg_next()), 1'b0, 1'b0);
    end
    // At full only the pop is taken.
    drive_cycle(1'b1, data_t'(lcg_next()), 1'b1, 1'b0);
    while (model_q.size() > 0) begin
      drive_cycle(1'b0, '0, 1'b1, 1'b0);
    end
    // At empty only the push is taken.
    drive_cycle(1'b1, data_t'(lcg_next()), 1'b1, 1'b0);
    for (int i = 0; i < 300; i++) begin
      r = lcg_next();
      // Phases of 50 cycles lean towards filling, then towards draining.
      if (((i / 50) % 2) == 0) begin
        push = (r[31:30] != 2'b00);
        pop  = (r[29:28] == 2'b00);
      end else begin
        push = (r[31:30] == 2'b00);
        pop  = (r[29:28] != 2'b00);
      end
      drive_cycle(push, data_t'(lcg_next()), pop, 1'b0);
    end
    while (model_q.size() > 0) begin
      drive_cycle(1'b0, '0, 1'b1, 1'b0);
    end
  endtask

  task automatic clear_flush();
    data_t new_word;
    repeat (5) drive_cycle(1'b1, data_t'(lcg_next()), 1'b0, 1'b0);
    drive_cycle(1'b1, data_t'(lcg_next()), 1'b1, 1'b1);
    check_value("o_empty", 64'(o_empty), 64'd1);
    check_value("o_count", 64'(o_count), 64'd0);
    new_word = data_t'(lcg_next());
    drive_cycle(1'b1, new_word, 1'b0, 1'b0);
    drive_cycle(1'b0, '0, 1'b1, 1'b0);
    check_value("o_pop_data", 64'(o_pop_data), 64'(new_word));
    drive_cycle(1'b0, '0, 1'b0, 1'b0);
  endtask

  initial begin
    i_rst_n     = 1'b0;
    i_clr       = 1'b0;
    i_push      = 1'b0;
    i_push_data = '0;
    i_pop       = 1'b0;
    lcg_state   = 32'd87083;
    exp_valid   = 1'b0;
    exp_data    = '0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    check_reset_state();
    fill_and_drain();
    overflow_drop();
    underflow_ignore();
    mixed_traffic();
    clear_flush();

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
fifo_pkg.sv
ram_wr_if.sv
dp_ram.sv
fifo_write_ctrl.sv
fifo_read_ctrl.sv
fifo_top.sv
tb_fifo.sv

// File: Makefile
# Builds and runs the FIFO testbench with Verilator.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_fifo
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
BIN       ?= V$(TOP)

.PHONY: sim clean

# The simulator exits with a non-zero status when the testbench stops with $fatal.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(BIN) -f $(FILELIST)
	./$(BUILD_DIR)/$(BIN)

clean:
	rm -rf $(BUILD_DIR)
